//--- src/can_pkg.sv
package can_pkg;

	// ==================================================
	// Serial ports
	// ==================================================

	localparam int PORT_NUM = 4;

	// Start bit, 8 data bits LSB first, stop bit
	localparam int FRAME_BITS = 10;

	// Transmit error counter
	localparam int TEC_W         = 6;
	localparam int ERR_INC       = 8;
	localparam int BUS_OFF_LIMIT = 32;

	localparam logic [7:0] PRESCALE_RST = 8'd4; // CLK cycles per bit

	// Port reset held this long after RST falls
	localparam int RELEASE_CYCLES = 64;

	typedef enum logic [1:0] {
		PORT_IDLE,
		PORT_SHIFT,
		PORT_BUSOFF // left only through reset
	} port_state_e;

endpackage

//--- src/mpc_bus_pkg.sv
package mpc_bus_pkg;

	// ==================================================
	// Local bus target side
	// ==================================================

	localparam int DATA_W = 32;

	typedef enum logic [1:0] {
		IDLE,
		CLAIMED, // S_READY high, waiting for S_DATA_VLD
		DONE     // one cycle of S_TERM or S_ABORT
	} tgt_state_e;

	// Word offsets from ADDR[7:2]
	typedef enum logic [5:0] {
		REG_STATUS   = 6'd0,
		REG_PRESCALE = 6'd1,
		REG_INT_MASK = 6'd2,
		REG_INT_PEND = 6'd3,
		REG_PORT0    = 6'd4  // port p at REG_PORT0 + p
	} reg_addr_e;

	localparam int REG_LAST = 4 + can_pkg::PORT_NUM - 1;

endpackage

//--- src/reg_bus_if.sv
interface reg_bus_if;

	mpc_bus_pkg::reg_addr_e addr;
	logic wr; // one-cycle pulses
	logic rd;
	logic [mpc_bus_pkg::DATA_W/8-1:0] be;
	logic [mpc_bus_pkg::DATA_W-1:0] wdata;
	logic [mpc_bus_pkg::DATA_W-1:0] rdata;

	modport tgt (
		output addr, wr, rd, be, wdata,
		input  rdata
	);

	modport regs (
		input  addr, wr, rd, be, wdata,
		output rdata
	);

endinterface

//--- src/target_fsm.sv
module target_fsm (
	input  logic CLK,
	input  logic RST,
	input  logic [mpc_bus_pkg::DATA_W-1:0] addr_i,
	input  logic addr_vld_i,
	input  logic [7:0] base_hit_i,
	input  logic wrdn_i,
	input  logic data_vld_i,
	input  logic [mpc_bus_pkg::DATA_W/8-1:0] cbe_i,
	input  logic [mpc_bus_pkg::DATA_W-1:0] wdata_i,
	output logic [mpc_bus_pkg::DATA_W-1:0] rdata_o,
	output logic ready_o,
	output logic term_o,
	output logic abort_o,
	reg_bus_if.tgt bus
);

	mpc_bus_pkg::tgt_state_e state_q;
	logic [5:0] offs_q;
	logic valid_q;
	logic is_wr_q;
	logic [mpc_bus_pkg::DATA_W/8-1:0] be_q;
	logic [mpc_bus_pkg::DATA_W-1:0] wdata_q;

	always_ff @(posedge CLK, posedge RST) begin
		if (RST) begin
			state_q <= mpc_bus_pkg::IDLE;
		end else begin
			case (state_q)
				mpc_bus_pkg::IDLE: begin
					if (addr_vld_i && base_hit_i[0])
						state_q <= mpc_bus_pkg::CLAIMED;
				end
				mpc_bus_pkg::CLAIMED: begin
					if (data_vld_i)
						state_q <= mpc_bus_pkg::DONE;
				end
				default: state_q <= mpc_bus_pkg::IDLE;
			endcase
		end
	end

	// Access details, captured on claim and on the data phase
	always_ff @(posedge CLK) begin
		if (state_q == mpc_bus_pkg::IDLE && addr_vld_i) begin
			offs_q  <= addr_i[7:2];
			valid_q <= addr_i[7:2] <= mpc_bus_pkg::REG_LAST;
		end
		if (state_q == mpc_bus_pkg::CLAIMED && data_vld_i) begin
			wdata_q <= wdata_i;
			be_q    <= ~cbe_i; // S_CBE is active low
			is_wr_q <= wrdn_i;
		end
	end

	assign ready_o = state_q == mpc_bus_pkg::CLAIMED;
	assign term_o  = state_q == mpc_bus_pkg::DONE && valid_q;
	assign abort_o = state_q == mpc_bus_pkg::DONE && !valid_q;

	// Register access happens in the DONE cycle, never for a bad offset
	assign bus.addr  = mpc_bus_pkg::reg_addr_e'(offs_q);
	assign bus.wr    = term_o && is_wr_q;
	assign bus.rd    = term_o && !is_wr_q;
	assign bus.be    = be_q;
	assign bus.wdata = wdata_q;
	assign rdata_o   = bus.rdata; // valid while S_TERM of a read

	a_term_abort_excl: assert property (@(posedge CLK) disable iff (RST)
		!(term_o && abort_o));

endmodule

//--- src/reset_release_timer.sv
module reset_release_timer (
	input  logic CLK,
	input  logic RST,
	output logic core_rst_o
);

	logic [$clog2(can_pkg::RELEASE_CYCLES+1)-1:0] cnt_q;

	// Saturates at RELEASE_CYCLES, core reset drops on that edge
	always_ff @(posedge CLK, posedge RST) begin
		if (RST) begin
			cnt_q      <= '0;
			core_rst_o <= 1'b1;
		end else if (cnt_q != can_pkg::RELEASE_CYCLES) begin
			cnt_q      <= cnt_q + 1'b1;
			core_rst_o <= cnt_q != can_pkg::RELEASE_CYCLES - 1;
		end
	end

endmodule

//--- src/bit_timer.sv
module bit_timer (
	input  logic CLK,
	input  logic rst_i,
	input  logic [7:0] prescale_i,
	output logic tick_o
);

	logic [7:0] cnt_q;
	logic [7:0] presc_q; // prescale seen last cycle

	always_ff @(posedge CLK, posedge rst_i) begin
		if (rst_i) begin
			cnt_q   <= '0;
			presc_q <= can_pkg::PRESCALE_RST;
		end else begin
			presc_q <= prescale_i;
			if (prescale_i != presc_q || tick_o)
				cnt_q <= '0; // restart on wrap or new bit time
			else
				cnt_q <= cnt_q + 1'b1;
		end
	end

	assign tick_o = cnt_q == presc_q - 8'd1;

	// Shorter bit times break the one-tick-per-bit frame timing
	a_prescale_min: assert property (@(posedge CLK) disable iff (rst_i)
		prescale_i >= 8'd2);

endmodule

//--- src/can_port.sv
module can_port (
	input  logic CLK,
	input  logic rst_i,
	input  logic tick_i,
	input  logic start_i,
	input  logic [7:0] tx_byte_i,
	input  logic rx_i,
	output logic tx_o,
	output logic [7:0] rx_byte_o,
	output logic done_o,
	output logic bus_off_o
);

	can_pkg::port_state_e state_q;
	logic [can_pkg::FRAME_BITS-1:0] frame_q;
	logic [$clog2(can_pkg::FRAME_BITS+1)-1:0] bit_cnt_q;
	logic [7:0] rx_sr_q;
	logic [can_pkg::TEC_W-1:0] tec_q;
	logic [can_pkg::TEC_W:0] tec_next;
	logic frame_end;

	assign frame_end = state_q == can_pkg::PORT_SHIFT && tick_i
		&& bit_cnt_q == can_pkg::FRAME_BITS;

	// ==================================================
	// Error counter step
	// ==================================================
	always_comb begin
		if (rx_sr_q != frame_q[8:1])
			tec_next = {1'b0, tec_q} + (can_pkg::TEC_W+1)'(can_pkg::ERR_INC);
		else if (tec_q != '0)
			tec_next = {1'b0, tec_q} - 1'b1;
		else
			tec_next = '0; // floor at zero
	end

	always_ff @(posedge CLK, posedge rst_i) begin
		if (rst_i) begin
			state_q   <= can_pkg::PORT_IDLE;
			bit_cnt_q <= '0;
			tec_q     <= '0;
			tx_o      <= 1'b1;
			done_o    <= 1'b0;
		end else begin
			done_o <= frame_end;
			case (state_q)
				can_pkg::PORT_IDLE: begin
					if (start_i) begin
						state_q   <= can_pkg::PORT_SHIFT; // first bit waits for a tick
						bit_cnt_q <= '0;
					end
				end
				can_pkg::PORT_SHIFT: begin
					if (frame_end) begin
						tx_o    <= 1'b1;
						tec_q   <= tec_next[can_pkg::TEC_W-1:0];
						state_q <= tec_next >= can_pkg::BUS_OFF_LIMIT ?
							can_pkg::PORT_BUSOFF : can_pkg::PORT_IDLE;
					end else if (tick_i) begin
						tx_o      <= frame_q[bit_cnt_q];
						bit_cnt_q <= bit_cnt_q + 1'b1;
					end
				end
				default: tx_o <= 1'b1;
			endcase
		end
	end

	// Data bit d is sampled on the tick with bit_cnt_q == d + 2
	always_ff @(posedge CLK) begin
		if (state_q == can_pkg::PORT_IDLE && start_i)
			frame_q <= {1'b1, tx_byte_i, 1'b0};
		if (state_q == can_pkg::PORT_SHIFT && tick_i && bit_cnt_q >= 2
			&& bit_cnt_q < can_pkg::FRAME_BITS)
			rx_sr_q <= {rx_i, rx_sr_q[7:1]};
		if (frame_end)
			rx_byte_o <= rx_sr_q;
	end

	assign bus_off_o = state_q == can_pkg::PORT_BUSOFF;

	a_busoff_recessive: assert property (@(posedge CLK) disable iff (rst_i)
		state_q == can_pkg::PORT_BUSOFF |-> tx_o);

endmodule

//--- src/mpc_regs.sv
module mpc_regs (
	input  logic CLK,
	input  logic RST,
	input  logic core_rst_i,
	reg_bus_if.regs bus,
	input  logic [can_pkg::PORT_NUM-1:0][7:0] rx_byte_i,
	input  logic [can_pkg::PORT_NUM-1:0] done_i,
	input  logic [can_pkg::PORT_NUM-1:0] bus_off_i,
	output logic [7:0] prescale_o,
	output logic [can_pkg::PORT_NUM-1:0] start_o,
	output logic [can_pkg::PORT_NUM-1:0][7:0] tx_byte_o,
	output logic int_n_o
);

	logic [7:0] prescale_q;
	logic [can_pkg::PORT_NUM-1:0] int_mask_q;
	logic [can_pkg::PORT_NUM-1:0] int_pend_q;
	logic [can_pkg::PORT_NUM-1:0] port_sel;
	logic [can_pkg::PORT_NUM-1:0] start_q;
	logic [can_pkg::PORT_NUM-1:0][7:0] tx_byte_q;
	logic [mpc_bus_pkg::DATA_W-1:0] rdata;
	logic int_n_q;

	always_comb begin
		for (int p = 0; p < can_pkg::PORT_NUM; p++) begin
			port_sel[p] = bus.addr == 6'(mpc_bus_pkg::REG_PORT0 + p);
		end
	end

	// ==================================================
	// Control registers
	// ==================================================
	always_ff @(posedge CLK, posedge RST) begin
		if (RST) begin
			prescale_q <= can_pkg::PRESCALE_RST;
			int_mask_q <= '0;
			int_pend_q <= '0;
			start_q    <= '0;
			int_n_q    <= 1'b1;
		end else begin
			start_q <= bus.wr ? port_sel : '0;
			int_n_q <= !(|(int_pend_q & int_mask_q));
			if (bus.wr && bus.be[0] && bus.addr == mpc_bus_pkg::REG_PRESCALE)
				prescale_q <= bus.wdata[7:0];
			if (bus.wr && bus.be[0] && bus.addr == mpc_bus_pkg::REG_INT_MASK)
				int_mask_q <= bus.wdata[can_pkg::PORT_NUM-1:0];
			// Write 1 to clear, a new done still sets
			if (bus.wr && bus.addr == mpc_bus_pkg::REG_INT_PEND)
				int_pend_q <= (int_pend_q & ~bus.wdata[can_pkg::PORT_NUM-1:0]) | done_i;
			else
				int_pend_q <= int_pend_q | done_i;
		end
	end

	always_ff @(posedge CLK) begin
		for (int p = 0; p < can_pkg::PORT_NUM; p++) begin
			if (bus.wr && port_sel[p])
				tx_byte_q[p] <= bus.wdata[7:0];
		end
	end

	// Read mux
	always_comb begin
		rdata = '0;
		case (bus.addr)
			mpc_bus_pkg::REG_STATUS: begin
				rdata[0] = !core_rst_i;
				rdata[8 +: can_pkg::PORT_NUM] = bus_off_i;
			end
			mpc_bus_pkg::REG_PRESCALE: rdata[7:0] = prescale_q;
			mpc_bus_pkg::REG_INT_MASK: rdata[can_pkg::PORT_NUM-1:0] = int_mask_q;
			mpc_bus_pkg::REG_INT_PEND: rdata[can_pkg::PORT_NUM-1:0] = int_pend_q;
			default: begin
				for (int p = 0; p < can_pkg::PORT_NUM; p++) begin
					if (port_sel[p])
						rdata[7:0] = rx_byte_i[p];
				end
			end
		endcase
	end

	assign bus.rdata  = bus.rd ? rdata : '0;
	assign prescale_o = prescale_q;
	assign start_o    = start_q;
	assign tx_byte_o  = tx_byte_q;
	assign int_n_o    = int_n_q;

endmodule

//--- src/mpc_wrapper.sv
module mpc_wrapper (
	input  logic CLK,
	input  logic RST,
	input  logic [31:0] ADDR,
	input  logic ADDR_VLD,
	input  logic [7:0] BASE_HIT,
	output logic [31:0] ADIO_IN,
	input  logic [31:0] ADIO_OUT,
	output logic S_TERM,
	output logic S_READY,
	output logic S_ABORT,
	input  logic S_WRDN,
	input  logic S_DATA_VLD,
	input  logic [3:0] S_CBE,
	output logic INT_N,

	// Serial ports
	input  logic [can_pkg::PORT_NUM-1:0] rx_i,
	output logic [can_pkg::PORT_NUM-1:0] tx_o,
	output logic [can_pkg::PORT_NUM-1:0] bus_off_on
);

	logic core_rst;
	logic tick;
	logic [7:0] prescale;
	logic [can_pkg::PORT_NUM-1:0] start;
	logic [can_pkg::PORT_NUM-1:0] done;
	logic [can_pkg::PORT_NUM-1:0][7:0] tx_byte;
	logic [can_pkg::PORT_NUM-1:0][7:0] rx_byte;

	reg_bus_if u_bus ();

	target_fsm u_target (
		.CLK        (CLK),
		.RST        (RST),
		.addr_i     (ADDR),
		.addr_vld_i (ADDR_VLD),
		.base_hit_i (BASE_HIT),
		.wrdn_i     (S_WRDN),
		.data_vld_i (S_DATA_VLD),
		.cbe_i      (S_CBE),
		.wdata_i    (ADIO_OUT),
		.rdata_o    (ADIO_IN),
		.ready_o    (S_READY),
		.term_o     (S_TERM),
		.abort_o    (S_ABORT),
		.bus        (u_bus.tgt)
	);

	reset_release_timer u_release (
		.CLK        (CLK),
		.RST        (RST),
		.core_rst_o (core_rst)
	);

	bit_timer u_bit_timer (
		.CLK        (CLK),
		.rst_i      (core_rst),
		.prescale_i (prescale),
		.tick_o     (tick)
	);

	mpc_regs u_regs (
		.CLK        (CLK),
		.RST        (RST),
		.core_rst_i (core_rst),
		.bus        (u_bus.regs),
		.rx_byte_i  (rx_byte),
		.done_i     (done),
		.bus_off_i  (bus_off_on),
		.prescale_o (prescale),
		.start_o    (start),
		.tx_byte_o  (tx_byte),
		.int_n_o    (INT_N)
	);

	generate
		for (genvar p = 0; p < can_pkg::PORT_NUM; p++) begin : g_port
			can_port u_port (
				.CLK       (CLK),
				.rst_i     (core_rst),
				.tick_i    (tick),
				.start_i   (start[p]),
				.tx_byte_i (tx_byte[p]),
				.rx_i      (rx_i[p]),
				.tx_o      (tx_o[p]),
				.rx_byte_o (rx_byte[p]),
				.done_o    (done[p]),
				.bus_off_o (bus_off_on[p])
			);
		end
	endgenerate

endmodule

//--- test/clk_gen.sv
module clk_gen (
	output logic clk_o,
	output logic rst_o
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk_o = 1'b0;
		forever #2 clk_o = ~clk_o; // 4 ns period
	end

	initial begin
		rst_o = 1'b1;
		repeat (4) @(posedge clk_o);
		#1 rst_o = 1'b0;
	end

endmodule

//--- test/tb_mpc.sv
module tb_mpc;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_REG_OPS       = 16;
	localparam int N_RANDOM_FRAMES = 40;
	localparam int N_XFER          = 80; // upper bound over both frame phases
	localparam int MAX_PRESCALE    = 16;
	localparam int TIMEOUT_CYCLES  = N_XFER * can_pkg::FRAME_BITS * MAX_PRESCALE + 7200;
	localparam int POLL_LIMIT      = 100;

	logic CLK;
	logic RST;
	logic [31:0] ADDR;
	logic ADDR_VLD;
	logic [7:0] BASE_HIT;
	logic [31:0] ADIO_IN;
	logic [31:0] ADIO_OUT;
	logic S_TERM;
	logic S_READY;
	logic S_ABORT;
	logic S_WRDN;
	logic S_DATA_VLD;
	logic [3:0] S_CBE;
	logic INT_N;
	logic [can_pkg::PORT_NUM-1:0] rx;
	logic [can_pkg::PORT_NUM-1:0] tx;
	logic [can_pkg::PORT_NUM-1:0] bus_off;
	logic [can_pkg::PORT_NUM-1:0] inject;

	integer seed = 32'hd3ff681a;
	int errors = 0;
	int cyc = 0;
	int rst_cyc;

	// Reference model
	logic [7:0] m_prescale;
	logic [can_pkg::PORT_NUM-1:0] m_mask;
	logic [can_pkg::PORT_NUM-1:0] m_busoff;
	int m_tec [can_pkg::PORT_NUM];

	assign rx = tx ^ inject; // loopback, inverted on injected frames

	clk_gen u_clk (
		.clk_o (CLK),
		.rst_o (RST)
	);

	mpc_wrapper u_dut (
		.CLK        (CLK),
		.RST        (RST),
		.ADDR       (ADDR),
		.ADDR_VLD   (ADDR_VLD),
		.BASE_HIT   (BASE_HIT),
		.ADIO_IN    (ADIO_IN),
		.ADIO_OUT   (ADIO_OUT),
		.S_TERM     (S_TERM),
		.S_READY    (S_READY),
		.S_ABORT    (S_ABORT),
		.S_WRDN     (S_WRDN),
		.S_DATA_VLD (S_DATA_VLD),
		.S_CBE      (S_CBE),
		.INT_N      (INT_N),
		.rx_i       (rx),
		.tx_o       (tx),
		.bus_off_on (bus_off)
	);

	always @(posedge CLK) cyc <= cyc + 1;

	initial begin
		wait (cyc >= TIMEOUT_CYCLES);
		$display("Timeout: the run did not finish within %0d cycles", cyc);
		$display("ERRORS FOUND");
		$finish;
	end

	// ==================================================
	// Compare tasks
	// ==================================================
	task automatic check_word(input string name, input logic [mpc_bus_pkg::DATA_W-1:0] got,
		input logic [mpc_bus_pkg::DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s = %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_ports(input string name, input logic [can_pkg::PORT_NUM-1:0] got,
		input logic [can_pkg::PORT_NUM-1:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s = %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	// ==================================================
	// Local bus access
	// ==================================================
	task automatic next_cycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic bus_access(input logic wr, input logic [5:0] offs, input logic [31:0] wdata,
		input logic [3:0] cbe, output logic [31:0] rdata, output logic term, output logic abort);
		ADDR     = {24'($random(seed)), offs, 2'b00};
		ADDR_VLD = 1'b1;
		BASE_HIT = 8'($random(seed)) | 8'h01;
		next_cycle();
		ADDR_VLD = 1'b0;
		BASE_HIT = 8'h00;
		check_flag("S_READY", S_READY, 1'b1);
		S_WRDN     = wr;
		ADIO_OUT   = wdata;
		S_CBE      = cbe;
		S_DATA_VLD = 1'b1;
		next_cycle();
		term  = S_TERM; // one cycle after the data strobe
		abort = S_ABORT;
		rdata = ADIO_IN;
		S_DATA_VLD = 1'b0;
		next_cycle();
		check_flag("S_TERM", S_TERM, 1'b0);
		check_flag("S_ABORT", S_ABORT, 1'b0);
	endtask

	task automatic write_reg(input logic [5:0] offs, input logic [31:0] wdata,
		input logic [3:0] cbe);
		logic [31:0] unused;
		logic term;
		logic abort;
		bus_access(1'b1, offs, wdata, cbe, unused, term, abort);
		check_flag("S_TERM", term, 1'b1);
		check_flag("S_ABORT", abort, 1'b0);
	endtask

	task automatic read_reg(input logic [5:0] offs, output logic [31:0] rdata);
		logic term;
		logic abort;
		bus_access(1'b0, offs, 32'($random(seed)), 4'h0, rdata, term, abort);
		check_flag("S_TERM", term, 1'b1);
		check_flag("S_ABORT", abort, 1'b0);
	endtask

	task automatic write_prescale();
		logic [31:0] data;
		logic [3:0] cbe;
		logic [7:0] presc;
		cbe   = 4'($random(seed));
		presc = 8'(2 + {$random(seed)} % 15);
		write_reg(mpc_bus_pkg::REG_PRESCALE, {24'($random(seed)), presc}, cbe);
		if (!cbe[0])
			m_prescale = presc; // lane 0 enabled
		read_reg(mpc_bus_pkg::REG_PRESCALE, data);
		check_word("ADIO_IN PRESCALE", data, {24'h0, m_prescale});
	endtask

	task automatic write_mask();
		logic [31:0] data;
		logic [31:0] wdata;
		logic [3:0] cbe;
		cbe   = 4'($random(seed));
		wdata = $random(seed);
		write_reg(mpc_bus_pkg::REG_INT_MASK, wdata, cbe);
		if (!cbe[0])
			m_mask = wdata[can_pkg::PORT_NUM-1:0];
		read_reg(mpc_bus_pkg::REG_INT_MASK, data);
		check_word("ADIO_IN INT_MASK", data, 32'(m_mask));
	endtask

	task automatic check_status();
		logic [31:0] data;
		read_reg(mpc_bus_pkg::REG_STATUS, data);
		check_word("ADIO_IN STATUS", data, 32'h1 | (32'(m_busoff) << 8));
		check_ports("bus_off_on", bus_off, m_busoff);
	endtask

	// ==================================================
	// Test phases
	// ==================================================
	task automatic test_reset_release();
		logic [31:0] data;
		check_flag("S_READY", S_READY, 1'b0);
		check_flag("S_TERM", S_TERM, 1'b0);
		check_flag("S_ABORT", S_ABORT, 1'b0);
		check_flag("INT_N", INT_N, 1'b1);
		check_ports("tx_o", tx, '1);
		read_reg(mpc_bus_pkg::REG_STATUS, data);
		check_word("ADIO_IN STATUS", data, 32'h0); // ports still held
		while (cyc - rst_cyc < can_pkg::RELEASE_CYCLES + 2)
			next_cycle();
		check_status();
		read_reg(mpc_bus_pkg::REG_PRESCALE, data);
		check_word("ADIO_IN PRESCALE", data, 32'(can_pkg::PRESCALE_RST));
		read_reg(mpc_bus_pkg::REG_INT_MASK, data);
		check_word("ADIO_IN INT_MASK", data, 32'h0);
		read_reg(mpc_bus_pkg::REG_INT_PEND, data);
		check_word("ADIO_IN INT_PEND", data, 32'h0);
	endtask

	task automatic test_decode();
		logic [31:0] data;
		logic term;
		logic abort;
		logic [5:0] offs;
		repeat (8) begin
			offs = 6'(mpc_bus_pkg::REG_LAST + 1 + {$random(seed)} % (63 - mpc_bus_pkg::REG_LAST));
			bus_access(1'($random(seed)), offs, $random(seed), 4'h0, data, term, abort);
			check_flag("S_ABORT", abort, 1'b1);
			check_flag("S_TERM", term, 1'b0);
		end
		// Strobe without BASE_HIT bit 0 is not claimed
		ADDR     = {24'h0, 6'(mpc_bus_pkg::REG_PRESCALE), 2'b00};
		ADDR_VLD = 1'b1;
		BASE_HIT = 8'($random(seed)) & 8'hfe;
		next_cycle();
		ADDR_VLD = 1'b0;
		BASE_HIT = 8'h00;
		check_flag("S_READY", S_READY, 1'b0);
		S_WRDN     = 1'b1;
		ADIO_OUT   = 32'h0;
		S_CBE      = 4'h0;
		S_DATA_VLD = 1'b1;
		next_cycle();
		S_DATA_VLD = 1'b0;
		repeat (2) begin
			check_flag("S_TERM", S_TERM, 1'b0);
			check_flag("S_ABORT", S_ABORT, 1'b0);
			next_cycle();
		end
		read_reg(mpc_bus_pkg::REG_PRESCALE, data);
		check_word("ADIO_IN PRESCALE", data, {24'h0, m_prescale});
	endtask

	task automatic run_frame(input int p, input logic [7:0] data, input logic err);
		logic [31:0] rd;
		logic [7:0] exp_byte;
		int polls;
		inject[p] = err;
		write_reg(6'(mpc_bus_pkg::REG_PORT0 + p), {24'($random(seed)), data},
			4'($random(seed)));
		if (m_busoff[p]) begin
			// Start must be dropped, line stays recessive
			repeat ((can_pkg::FRAME_BITS + 2) * m_prescale + 4) begin
				next_cycle();
				check_flag($sformatf("tx_o[%0d]", p), tx[p], 1'b1);
			end
			inject[p] = 1'b0;
			read_reg(mpc_bus_pkg::REG_INT_PEND, rd);
			check_word("ADIO_IN INT_PEND", rd, 32'h0);
		end else begin
			rd    = '0;
			polls = 0;
			while (rd[p] !== 1'b1 && polls < POLL_LIMIT) begin
				read_reg(mpc_bus_pkg::REG_INT_PEND, rd);
				polls++;
			end
			inject[p] = 1'b0;
			if (rd[p] !== 1'b1) begin
				$display("Port %0d never finished its frame at %0t", p, $time);
				errors++;
			end
			check_word("ADIO_IN INT_PEND", rd, 32'd1 << p);
			if (err)
				m_tec[p] += can_pkg::ERR_INC;
			else if (m_tec[p] > 0)
				m_tec[p]--;
			if (m_tec[p] >= can_pkg::BUS_OFF_LIMIT)
				m_busoff[p] = 1'b1;
			exp_byte = err ? ~data : data;
			check_flag("INT_N", INT_N, !m_mask[p]);
			read_reg(6'(mpc_bus_pkg::REG_PORT0 + p), rd);
			check_word($sformatf("ADIO_IN PORT%0d", p), rd, {24'h0, exp_byte});
			check_status();
			write_reg(mpc_bus_pkg::REG_INT_PEND, 32'd1 << p, 4'($random(seed)));
			next_cycle(); // INT_N lags the pending bits
			check_flag("INT_N", INT_N, 1'b1);
			read_reg(mpc_bus_pkg::REG_INT_PEND, rd);
			check_word("ADIO_IN INT_PEND", rd, 32'h0);
		end
	endtask

	initial begin
		ADDR       = '0;
		ADDR_VLD   = 1'b0;
		BASE_HIT   = '0;
		ADIO_OUT   = '0;
		S_WRDN     = 1'b0;
		S_DATA_VLD = 1'b0;
		S_CBE      = '1;
		inject     = '0;
		m_prescale = can_pkg::PRESCALE_RST;
		m_mask     = '0;
		m_busoff   = '0;
		foreach (m_tec[i])
			m_tec[i] = 0;

		@(negedge RST);
		rst_cyc = cyc;
		test_reset_release();

		repeat (N_REG_OPS) begin
			write_prescale();
			write_mask();
		end
		test_decode();

		repeat (N_RANDOM_FRAMES) begin
			write_prescale();
			write_mask();
			run_frame({$random(seed)} % can_pkg::PORT_NUM, 8'($random(seed)),
				({$random(seed)} % 3) == 0);
		end

		// Drive every port to bus-off, then try one more start
		for (int p = 0; p < can_pkg::PORT_NUM; p++) begin
			while (!m_busoff[p])
				run_frame(p, 8'($random(seed)), 1'b1);
			run_frame(p, 8'($random(seed)), 1'b0);
		end
		check_ports("tx_o", tx, '1);

		$display("Run complete, %0d errors", errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- src.f
src/can_pkg.sv
src/mpc_bus_pkg.sv
src/reg_bus_if.sv
src/target_fsm.sv
src/reset_release_timer.sv
src/bit_timer.sv
src/can_port.sv
src/mpc_regs.sv
src/mpc_wrapper.sv
test/clk_gen.sv
test/tb_mpc.sv
